// File: logic/img_pkg.sv
package img_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int WORD_W        = 16;
    localparam int PIXEL_W       = 12;
    localparam int HEADER_WORDS  = 8;
    localparam int HEADER_W      = HEADER_WORDS * WORD_W;
    localparam int IMG_MAX_WORDS = 1024;
    localparam int BLOCK_AW      = $clog2(IMG_MAX_WORDS);
    localparam int COUNT_W       = $clog2(IMG_MAX_WORDS + 1);
    localparam int STAT_W        = 18;
    localparam int STAT_TOP_BITS = 7;

    // ======================================================================
    // Data types
    // ======================================================================
    typedef logic [WORD_W-1:0]   word_t;
    // Most significant word goes out first
    typedef logic [HEADER_W-1:0] header_t;
    typedef logic [COUNT_W-1:0]  count_t;
    typedef logic [STAT_W-1:0]   stat_t;

    typedef struct packed {
        logic               fv;
        logic               lv;
        logic [PIXEL_W-1:0] d;
    } pixel_in_t;

    typedef enum logic [0:0] {CMD_CAPTURE, CMD_READOUT} cmd_op_e;

    typedef struct packed {
        cmd_op_e op;
        logic    block;
        header_t header;
    } cmd_t;

    typedef struct packed {
        count_t word_count;
        stat_t  highlight_count;
        stat_t  shadow_count;
    } status_t;

    typedef enum logic [1:0] {RAM_NONE, RAM_WRITE, RAM_READ} ram_op_e;

    // Controller and capture FSM states
    typedef enum logic [2:0] {
        CTRL_IDLE, CTRL_CAP_ARM, CTRL_CAP_RUN, CTRL_CAP_DRAIN,
        CTRL_RD_ARM, CTRL_RD_RUN, CTRL_RD_DRAIN
    } ctrl_state_e;

    typedef enum logic [2:0] {
        CAP_IDLE, CAP_WAIT_FV_LOW, CAP_WAIT_FV_HIGH, CAP_HEADER, CAP_PIXELS
    } cap_state_e;

endpackage

// File: logic/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
    parameter int DEPTH = 16
) (
    input  logic          clk,
    input  logic          fifoIn_rst,
    input  logic          flush,
    input  img_pkg::word_t in_data,
    input  logic          in_valid,
    output logic          in_ready,
    output img_pkg::word_t out_data,
    output logic          out_valid,
    input  logic          out_ready
);
    import img_pkg::*;

    word_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]  wr_ptr;
    logic [$clog2(DEPTH)-1:0]  rd_ptr;
    logic [$clog2(DEPTH):0]    count;
    logic                      push;
    logic                      pop;

    // Top count bit set means exactly DEPTH words held
    assign in_ready  = !count[$clog2(DEPTH)];
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pointer distance matches occupancy, so no slot is overwritten or read while empty
    a_ptr_count: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        count[$clog2(DEPTH)-1:0] == wr_ptr - rd_ptr);

endmodule

// File: logic/frame_capture.sv
`timescale 1ns/1ps

module frame_capture (
    input  logic               clk,
    input  logic               fifoIn_rst,
    input  logic               start,
    input  img_pkg::header_t   header,
    input  img_pkg::pixel_in_t pix,
    output img_pkg::word_t     cap_word,
    output logic               cap_valid,
    input  logic               cap_ready,
    output logic               done,
    output img_pkg::status_t   status
);
    import img_pkg::*;

    cap_state_e                      state;
    header_t                         hdr_shift;
    logic [$clog2(HEADER_WORDS)-1:0] hdr_left;
    logic [1:0]                      x;
    logic [1:0]                      y;
    logic                            lv_prev;
    logic                            sample;
    logic [STAT_TOP_BITS-1:0]        top_bits;

    // ======================================================================
    // Sampling grid position
    // ======================================================================
    assign top_bits = pix.d[PIXEL_W-1 -: STAT_TOP_BITS];
    assign sample   = (state == CAP_PIXELS) && pix.fv && pix.lv &&
                      (x == 2'd0) && (y == 2'd0);

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            x       <= '0;
            y       <= '0;
            lv_prev <= 1'b0;
        end else begin
            lv_prev <= pix.lv;
            x <= pix.lv ? x + 1'b1 : 2'd0;
            // y steps on each line end
            if (!pix.fv) begin
                y <= '0;
            end else if (lv_prev && !pix.lv) begin
                y <= y + 1'b1;
            end
        end
    end

    // ======================================================================
    // Frame FSM and statistics
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state     <= CAP_IDLE;
            cap_valid <= 1'b0;
            done      <= 1'b0;
            hdr_left  <= '0;
            status    <= '0;
        end else begin
            cap_valid <= 1'b0;
            done      <= 1'b0;
            if (cap_valid && cap_ready) begin
                status.word_count <= status.word_count + 1'b1;
            end
            if (sample && (&top_bits)) begin
                status.highlight_count <= status.highlight_count + 1'b1;
            end
            if (sample && !(|top_bits)) begin
                status.shadow_count <= status.shadow_count + 1'b1;
            end
            case (state)
                CAP_WAIT_FV_LOW: begin
                    if (!pix.fv) state <= CAP_WAIT_FV_HIGH;
                end
                CAP_WAIT_FV_HIGH: begin
                    if (pix.fv) begin
                        cap_valid <= 1'b1;
                        hdr_left  <= '1;
                        state     <= CAP_HEADER;
                    end
                end
                CAP_HEADER: begin
                    cap_valid <= 1'b1;
                    hdr_left  <= hdr_left - 1'b1;
                    if (hdr_left == 'd1) state <= CAP_PIXELS;
                end
                CAP_PIXELS: begin
                    if (!pix.fv) begin
                        done  <= 1'b1;
                        state <= CAP_IDLE;
                    end else begin
                        cap_valid <= pix.lv;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
            if (start) begin
                state  <= CAP_WAIT_FV_LOW;
                status <= '0;
            end
        end
    end

    // Word payload, qualified by cap_valid
    always_ff @(posedge clk) begin
        if (state == CAP_WAIT_FV_HIGH) begin
            cap_word  <= header[HEADER_W-1 -: WORD_W];
            hdr_shift <= header << WORD_W;
        end else if (state == CAP_HEADER) begin
            cap_word  <= hdr_shift[HEADER_W-1 -: WORD_W];
            hdr_shift <= hdr_shift << WORD_W;
        end else begin
            cap_word <= {{(WORD_W - PIXEL_W){1'b0}}, pix.d};
        end
    end

    // The sensor cannot stall, so the input FIFO must always take the word
    a_no_drop: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        cap_valid |-> cap_ready);

endmodule

// File: logic/block_store.sv
`timescale 1ns/1ps

module block_store (
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  img_pkg::ram_op_e  ram_op,
    input  logic              ram_block,
    input  img_pkg::count_t   rd_len,
    input  img_pkg::word_t    wr_data,
    input  logic              wr_valid,
    output logic              wr_ready,
    output img_pkg::word_t    rd_data,
    output logic              rd_valid,
    input  logic              rd_ready,
    output logic              busy
);
    import img_pkg::*;

    word_t  mem [2 * IMG_MAX_WORDS];
    logic   wr_open;
    logic   wr_blk;
    count_t wr_addr;
    logic   rd_blk;
    count_t rd_addr;
    count_t rd_left;
    logic   rd_fire;

    assign wr_ready = wr_open;
    // Fetch the next word when the output stage is empty or being drained
    assign rd_fire  = (rd_left != '0) && (!rd_valid || rd_ready);
    assign busy     = (rd_left != '0) || rd_valid;

    always_ff @(posedge clk) begin
        if (wr_open && wr_valid) begin
            mem[{wr_blk, wr_addr[BLOCK_AW-1:0]}] <= wr_data;
        end
        if (rd_fire) begin
            rd_data <= mem[{rd_blk, rd_addr[BLOCK_AW-1:0]}];
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_open  <= 1'b0;
            wr_blk   <= 1'b0;
            wr_addr  <= '0;
            rd_blk   <= 1'b0;
            rd_addr  <= '0;
            rd_left  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_open && wr_valid) wr_addr <= wr_addr + 1'b1;
            if (rd_fire) begin
                rd_addr  <= rd_addr + 1'b1;
                rd_left  <= rd_left - 1'b1;
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
            case (ram_op)
                RAM_WRITE: begin
                    wr_open <= 1'b1;
                    wr_blk  <= ram_block;
                    wr_addr <= '0;
                end
                RAM_READ: begin
                    wr_open <= 1'b0;
                    rd_blk  <= ram_block;
                    rd_addr <= '0;
                    rd_left <= rd_len;
                end
                default: ;
            endcase
        end
    end

    a_block_bound: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (wr_open && wr_valid) |-> (wr_addr < IMG_MAX_WORDS));

endmodule

// File: logic/img_controller.sv
`timescale 1ns/1ps

module img_controller (
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  img_pkg::cmd_t     cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output logic              cap_start,
    output img_pkg::header_t  cap_header,
    input  logic              cap_done,
    input  img_pkg::count_t   cap_word_count,
    input  logic              in_fifo_empty,
    input  logic              store_busy,
    input  logic              out_fifo_empty,
    output img_pkg::ram_op_e  ram_op,
    output logic              ram_block,
    output img_pkg::count_t   rd_len,
    output logic              out_flush,
    output logic              capture_done
);
    import img_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    count_t      blk_words [2];
    logic        cmd_take;

    assign cmd_take = cmd_valid && cmd_ready;

    // ======================================================================
    // Sequencer
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            CTRL_IDLE: begin
                if (cmd_take) begin
                    state_nxt = (cmd.op == CMD_CAPTURE) ? CTRL_CAP_ARM : CTRL_RD_ARM;
                end
            end
            CTRL_CAP_ARM:   state_nxt = CTRL_CAP_RUN;
            CTRL_CAP_RUN:   if (cap_done) state_nxt = CTRL_CAP_DRAIN;
            // Last words still on their way into the store
            CTRL_CAP_DRAIN: if (in_fifo_empty) state_nxt = CTRL_IDLE;
            CTRL_RD_ARM:    state_nxt = CTRL_RD_RUN;
            CTRL_RD_RUN:    if (!store_busy) state_nxt = CTRL_RD_DRAIN;
            CTRL_RD_DRAIN:  if (out_fifo_empty) state_nxt = CTRL_IDLE;
            default:        state_nxt = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state        <= CTRL_IDLE;
            cmd_ready    <= 1'b0;
            cap_start    <= 1'b0;
            ram_op       <= RAM_NONE;
            ram_block    <= 1'b0;
            rd_len       <= '0;
            out_flush    <= 1'b0;
            capture_done <= 1'b0;
            blk_words[0] <= '0;
            blk_words[1] <= '0;
        end else begin
            state        <= state_nxt;
            cmd_ready    <= (state_nxt == CTRL_IDLE);
            cap_start    <= 1'b0;
            ram_op       <= RAM_NONE;
            out_flush    <= 1'b0;
            capture_done <= 1'b0;
            if (cmd_take) begin
                ram_block <= cmd.block;
                if (cmd.op == CMD_CAPTURE) begin
                    ram_op    <= RAM_WRITE;
                    cap_start <= 1'b1;
                end else begin
                    ram_op    <= RAM_READ;
                    rd_len    <= blk_words[cmd.block];
                    out_flush <= 1'b1;
                end
            end
            // Length of the last frame stored per block
            if ((state == CTRL_CAP_RUN) && cap_done) begin
                blk_words[ram_block] <= cap_word_count;
            end
            if ((state == CTRL_CAP_DRAIN) && in_fifo_empty) begin
                capture_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            cap_header <= cmd.header;
        end
    end

    // Capture only finishes a frame that this sequencer started
    a_done_in_run: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        cap_done |-> (state == CTRL_CAP_RUN));

endmodule

// File: logic/img_subsystem_top.sv
`timescale 1ns/1ps

module img_subsystem_top (
    input  logic               clk,
    input  logic               fifoIn_rst,
    input  img_pkg::cmd_t      cmd,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  img_pkg::pixel_in_t pix,
    output logic               capture_done,
    output img_pkg::status_t   status,
    output img_pkg::word_t     readout_data,
    output logic               readout_valid,
    input  logic               readout_ready
);
    import img_pkg::*;

    logic    cap_start;
    header_t cap_header;
    logic    cap_done;
    word_t   cap_word;
    logic    cap_valid;
    logic    cap_ready;
    word_t   wr_data;
    logic    wr_valid;
    logic    wr_ready;
    word_t   rd_data;
    logic    rd_valid;
    logic    rd_ready;
    logic    store_busy;
    ram_op_e ram_op;
    logic    ram_block;
    count_t  rd_len;
    logic    out_flush;

    img_controller u_ctrl (
        .clk(clk), .fifoIn_rst(fifoIn_rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cap_start(cap_start), .cap_header(cap_header), .cap_done(cap_done),
        .cap_word_count(status.word_count), .in_fifo_empty(!wr_valid),
        .store_busy(store_busy), .out_fifo_empty(!readout_valid),
        .ram_op(ram_op), .ram_block(ram_block), .rd_len(rd_len),
        .out_flush(out_flush), .capture_done(capture_done)
    );

    frame_capture u_capture (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .start(cap_start), .header(cap_header),
        .pix(pix), .cap_word(cap_word), .cap_valid(cap_valid), .cap_ready(cap_ready),
        .done(cap_done), .status(status)
    );

    // Input FIFO is cleared as each capture starts
    word_fifo u_fifo_in (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .flush(cap_start),
        .in_data(cap_word), .in_valid(cap_valid), .in_ready(cap_ready),
        .out_data(wr_data), .out_valid(wr_valid), .out_ready(wr_ready)
    );

    block_store u_store (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .ram_op(ram_op), .ram_block(ram_block),
        .rd_len(rd_len), .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .rd_data(rd_data), .rd_valid(rd_valid), .rd_ready(rd_ready), .busy(store_busy)
    );

    word_fifo u_fifo_out (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .flush(out_flush),
        .in_data(rd_data), .in_valid(rd_valid), .in_ready(rd_ready),
        .out_data(readout_data), .out_valid(readout_valid), .out_ready(readout_ready)
    );

endmodule

// File: verif/tb_img_top.sv
`timescale 1ns/1ps

module tb_img_top;
    import img_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int NUM_ROUNDS    = 4;
    localparam int NUM_FRAMES    = 2 * NUM_ROUNDS;
    // Worst case cycles for one frame and for one readout of it
    localparam int MAX_FRAME_CYC = 12 + 10 + 6 * (20 + 4) + 8;
    localparam int MAX_RD_CYC    = HEADER_WORDS + 6 * 20 + 16;
    localparam int WATCHDOG_CYC  = NUM_FRAMES * (MAX_FRAME_CYC + MAX_RD_CYC) * 4;

    logic      clk = 1'b0;
    logic      fifoIn_rst;
    cmd_t      cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    pixel_in_t pix;
    logic      capture_done;
    status_t   status;
    word_t     readout_data;
    logic      readout_valid;
    logic      readout_ready;

    integer seed       = 22982;
    // Own seed variable so back-pressure does not depend on process order
    integer ready_seed = 22982;
    int     errors     = 0;
    int     checks     = 0;
    int     accepts    = 0;
    int     issued     = 0;
    stat_t  exp_high;
    stat_t  exp_shadow;
    word_t  exp_blk0[$];
    word_t  exp_blk1[$];
    word_t  cur_q[$];
    word_t  rx_q[$];

    img_subsystem_top i_dut (
        .clk(clk), .fifoIn_rst(fifoIn_rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .pix(pix), .capture_done(capture_done), .status(status),
        .readout_data(readout_data), .readout_valid(readout_valid),
        .readout_ready(readout_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        readout_ready <= ($unsigned($random(ready_seed)) % 10) < 7;
    end

    // Handshakes seen half a cycle before the edge that completes them
    always @(negedge clk) begin
        if (fifoIn_rst) begin
            if (readout_valid && readout_ready) begin
                rx_q.push_back(readout_data);
            end
            if (cmd_valid && cmd_ready) begin
                accepts++;
            end
        end
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic check_count(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_stat(input string name, input stat_t got, input stat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ======================================================================
    // Stimulus and model
    // ======================================================================
    task automatic send_cmd(input cmd_op_e op, input logic blk, input header_t hdr);
        cmd_t c;
        c.op     = op;
        c.block  = blk;
        c.header = hdr;
        @(posedge clk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        issued++;
        do begin
            @(negedge clk);
        end while (!cmd_ready);
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic idle_cycles(input int n, input logic fv);
        repeat (n) begin
            @(posedge clk);
            pix.fv <= fv;
            pix.lv <= 1'b0;
        end
    endtask

    // Bias toward both ends of the range so grid samples hit highlight and shadow
    function automatic logic [PIXEL_W-1:0] pick_pixel(input logic [31:0] r);
        case (r[31:30])
            2'd0:    return {{STAT_TOP_BITS{1'b1}}, r[PIXEL_W-STAT_TOP_BITS-1:0]};
            2'd1:    return {{STAT_TOP_BITS{1'b0}}, r[PIXEL_W-STAT_TOP_BITS-1:0]};
            default: return r[PIXEL_W-1:0];
        endcase
    endfunction

    // 4x4 grid, classified by the top seven bits
    task automatic model_stats(input int ln, input int col, input logic [PIXEL_W-1:0] d);
        if ((ln % 4 == 0) && (col % 4 == 0)) begin
            if (d[PIXEL_W-1 -: STAT_TOP_BITS] == '1) begin
                exp_high++;
            end else if (d[PIXEL_W-1 -: STAT_TOP_BITS] == '0) begin
                exp_shadow++;
            end
        end
    endtask

    task automatic run_capture(input logic blk);
        header_t            hdr;
        logic [31:0]        r;
        logic [PIXEL_W-1:0] d;
        int                 i;
        int                 ln;
        int                 col;
        int                 n_lines;
        int                 n_pix;
        hdr = {$random(seed), $random(seed), $random(seed), $random(seed)};
        cur_q.delete();
        exp_high   = '0;
        exp_shadow = '0;
        for (i = 0; i < HEADER_WORDS; i++) begin
            cur_q.push_back(hdr[HEADER_W-1 - i*WORD_W -: WORD_W]);
        end
        send_cmd(CMD_CAPTURE, blk, hdr);
        // Blanking, long enough for the capture FSM to see fv low
        idle_cycles(4 + $unsigned($random(seed)) % 8, 1'b0);
        // Header time, with a stray command offered while busy
        idle_cycles(2, 1'b1);
        cmd_valid <= 1'b1;
        idle_cycles(2, 1'b1);
        cmd_valid <= 1'b0;
        idle_cycles(6, 1'b1);
        n_lines = 1 + $unsigned($random(seed)) % 6;
        for (ln = 0; ln < n_lines; ln++) begin
            n_pix = 4 + $unsigned($random(seed)) % 17;
            for (col = 0; col < n_pix; col++) begin
                r = $random(seed);
                d = pick_pixel(r);
                @(posedge clk);
                pix.fv <= 1'b1;
                pix.lv <= 1'b1;
                pix.d  <= d;
                cur_q.push_back(word_t'(d));
                model_stats(ln, col, d);
            end
            idle_cycles(1 + $unsigned($random(seed)) % 4, 1'b1);
        end
        idle_cycles(2, 1'b0);
        do begin
            @(negedge clk);
            if (cmd_ready && !capture_done) begin
                errors++;
                $display("cmd_ready went high at %0t before the capture finished", $time);
            end
        end while (!capture_done);
        if (!cmd_ready) begin
            errors++;
            $display("cmd_ready did not return high at the end of the capture");
        end
        check_count("status.word_count", status.word_count, count_t'(cur_q.size()));
        check_stat("status.highlight_count", status.highlight_count, exp_high);
        check_stat("status.shadow_count", status.shadow_count, exp_shadow);
        if (blk) begin
            exp_blk1 = cur_q;
        end else begin
            exp_blk0 = cur_q;
        end
    endtask

    task automatic run_readout(input logic blk);
        word_t exp_q[$];
        int    i;
        if (blk) begin
            exp_q = exp_blk1;
        end else begin
            exp_q = exp_blk0;
        end
        check_count("words out before readout", count_t'(rx_q.size()), '0);
        rx_q.delete();
        send_cmd(CMD_READOUT, blk, '0);
        do begin
            @(negedge clk);
        end while (!cmd_ready);
        check_count("readout word count", count_t'(rx_q.size()), count_t'(exp_q.size()));
        for (i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check_word("readout_data", rx_q[i], exp_q[i]);
        end
        rx_q.delete();
        repeat (4) begin
            @(negedge clk);
            if (readout_valid) begin
                errors++;
                $display("readout_valid went high at %0t after the readout ended", $time);
            end
        end
    endtask

    // ======================================================================
    // Test sequence and watchdog
    // ======================================================================
    initial begin
        logic [31:0] r;
        int          round;
        fifoIn_rst    = 1'b0;
        cmd           = '0;
        cmd_valid     = 1'b0;
        pix           = '0;
        readout_ready = 1'b0;
        repeat (3) @(posedge clk);
        fifoIn_rst <= 1'b1;
        for (round = 0; round < NUM_ROUNDS; round++) begin
            r = $random(seed);
            run_capture(r[0]);
            run_capture(!r[0]);
            r = $random(seed);
            run_readout(r[0]);
            run_readout(!r[0]);
        end
        check_count("accepted commands", count_t'(accepts), count_t'(issued));
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: filelist.f
logic/img_pkg.sv
logic/word_fifo.sv
logic/frame_capture.sv
logic/block_store.sv
logic/img_controller.sv
logic/img_subsystem_top.sv
verif/tb_img_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_img_top -f filelist.f -Mdir obj_dir -o tb_img_top

./obj_dir/tb_img_top | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
exit 1
